// ==== axi_rd_pkg.sv ====
`default_nettype none

package axi_rd_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// arsize encoding for a full-width beat
	localparam logic [2:0] AXI_SIZE_LOG2 = 3'($clog2(AXI_STRB_W));

	typedef enum logic [1:0] {
		AXI_BURST_FIXED = 2'b00,
		AXI_BURST_INCR  = 2'b01 // wrap is never issued
	} axi_burst_e;

	typedef enum logic [1:0] {
		AXI_RESP_OKAY   = 2'b00,
		AXI_RESP_EXOKAY = 2'b01,
		AXI_RESP_SLVERR = 2'b10,
		AXI_RESP_DECERR = 2'b11
	} axi_resp_e;

	localparam logic [3:0] AXI_CACHE_RD = 4'b0011; // normal non-cacheable bufferable
	localparam logic [2:0] AXI_PROT_RD  = 3'b000;

	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [7:0]            len; // beats - 1
		axi_burst_e            burst;
	} axi_ar_t;

	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		axi_resp_e             resp;
		logic                  last;
	} axi_r_t;

endpackage

`default_nettype wire

// ==== dma_mm2s_pkg.sv ====
`default_nettype none

package dma_mm2s_pkg;

	localparam int BTT_W = 24; // bytes to transfer

	// incrementing bursts stay inside one of these
	localparam int BOUNDARY_BYTES = 4096;

	// AXI caps fixed bursts at 16 beats
	localparam int FIXED_MAX_LEN = 16;

	// command as it arrives on the command stream
	typedef struct packed {
		logic [BTT_W-1:0]                  btt;
		logic [axi_rd_pkg::AXI_ADDR_W-1:0] base_addr;
		logic                              fixed;
	} mm2s_cmd_t;

	// command after decode, counted in beats
	typedef struct packed {
		logic [axi_rd_pkg::AXI_ADDR_W-1:0] base_addr;
		logic [BTT_W-1:0]                  beats;
		logic                              fixed;
		logic [axi_rd_pkg::AXI_STRB_W-1:0] first_keep;
		logic [axi_rd_pkg::AXI_STRB_W-1:0] last_keep;
	} mm2s_dcmd_t;

	// one record per issued burst
	typedef struct packed {
		logic [axi_rd_pkg::AXI_STRB_W-1:0] first_keep;
		logic [axi_rd_pkg::AXI_STRB_W-1:0] last_keep;
		logic                              last_burst; // closes the command
	} burst_info_t;

	typedef struct packed {
		logic [axi_rd_pkg::AXI_DATA_W-1:0] data;
		logic [axi_rd_pkg::AXI_STRB_W-1:0] keep;
		logic [1:0]                        user; // rresp of the beat
		logic                              last;
	} mm2s_beat_t;

endpackage

`default_nettype wire

// ==== mm2s_sync_fifo.sv ====
`default_nettype none

module mm2s_sync_fifo #(
	parameter int  DEPTH = 4,
	parameter type T     = logic
)(
	input  wire   m_axi_aclk,
	input  wire   m_axi_aresetn,
	input  wire T wr_i,
	input  wire   wr_valid_i,
	output logic  wr_ready_o,
	output T      rd_o,
	output logic  rd_valid_o,
	input  wire   rd_ready_i
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_fire;
	logic             rd_fire;

	assign wr_ready_o = (count != CNT_W'(DEPTH));
	assign rd_valid_o = (count != '0);
	assign rd_o       = mem[rd_ptr]; // head shows without a read strobe

	assign wr_fire = wr_valid_i & wr_ready_o;
	assign rd_fire = rd_valid_o & rd_ready_i;

	always_ff @(posedge m_axi_aclk)
	begin
		if (wr_fire)
			mem[wr_ptr] <= wr_i;
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_fire)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_fire != rd_fire)
				count <= wr_fire ? count + 1'b1 : count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== mm2s_cmd_decode.sv ====
`default_nettype none

module mm2s_cmd_decode (
	input  wire                           m_axi_aclk,
	input  wire                           m_axi_aresetn,
	input  wire dma_mm2s_pkg::mm2s_cmd_t  cmd_i,
	input  wire                           cmd_valid_i,
	output logic                          cmd_ready_o,
	output dma_mm2s_pkg::mm2s_dcmd_t      dcmd_o,
	output logic                          dcmd_valid_o,
	input  wire                           dcmd_ready_i
);
	import axi_rd_pkg::*;
	import dma_mm2s_pkg::*;

	localparam int OFS_W = $clog2(AXI_STRB_W);
	localparam int END_W = BTT_W + 1;

	logic [OFS_W-1:0]      start_ofs;
	logic [END_W-1:0]      end_addr; // only the unaligned start part of the address
	logic [OFS_W-1:0]      end_ofs;
	logic [BTT_W-1:0]      beats;
	logic [AXI_STRB_W-1:0] first_keep;
	logic [AXI_STRB_W-1:0] last_keep;

	assign start_ofs = cmd_i.base_addr[OFS_W-1:0];
	assign end_addr  = END_W'(cmd_i.btt) + END_W'(start_ofs);
	assign end_ofs   = end_addr[OFS_W-1:0];
	assign beats     = BTT_W'(end_addr[END_W-1:OFS_W]) + BTT_W'(|end_ofs); // round up

	always_comb
	begin
		for (int i = 0; i < AXI_STRB_W; i++)
		begin
			first_keep[i] = (start_ofs <= i);
			last_keep[i]  = (end_ofs > i) || (end_ofs == '0); // zero offset ends on a full beat
		end
	end

	// single slot, refilled while its item leaves
	assign cmd_ready_o = !dcmd_valid_o || dcmd_ready_i;

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			dcmd_valid_o <= 1'b0;
		else if (cmd_ready_o)
			dcmd_valid_o <= cmd_valid_i;
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (cmd_valid_i && cmd_ready_o)
			dcmd_o <= '{base_addr: cmd_i.base_addr, beats: beats, fixed: cmd_i.fixed,
				first_keep: first_keep, last_keep: last_keep};
	end

endmodule

`default_nettype wire

// ==== mm2s_burst_splitter.sv ====
`default_nettype none

module mm2s_burst_splitter #(
	parameter int MAX_BURST_LEN = 8
)(
	input  wire                           m_axi_aclk,
	input  wire                           m_axi_aresetn,
	input  wire dma_mm2s_pkg::mm2s_dcmd_t dcmd_i,
	input  wire                           dcmd_valid_i,
	output logic                          dcmd_ready_o,
	input  wire                           credit_ok_i,
	output axi_rd_pkg::axi_ar_t           ar_o,
	output logic                          arvalid_o,
	input  wire                           arready_i,
	output dma_mm2s_pkg::burst_info_t     info_o
);
	import axi_rd_pkg::*;
	import dma_mm2s_pkg::*;

	localparam int SIZE_LOG2 = $clog2(AXI_STRB_W);
	localparam int BND_LOG2  = $clog2(BOUNDARY_BYTES);
	localparam int BND_W     = BND_LOG2 - SIZE_LOG2; // beat index inside a 4 KB page
	localparam int FIXED_CAP = (MAX_BURST_LEN < FIXED_MAX_LEN) ? MAX_BURST_LEN : FIXED_MAX_LEN;
	localparam logic [BTT_W-1:0] INCR_CAP_SUB1  = BTT_W'(MAX_BURST_LEN - 1);
	localparam logic [BTT_W-1:0] FIXED_CAP_SUB1 = BTT_W'(FIXED_CAP - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CMP0, // min(remaining, burst cap)
		ST_CMP1, // min(previous, room before boundary)
		ST_LAUNCH
	} state_e;

	state_e                state;
	logic [AXI_ADDR_W-1:0] araddr;
	logic [AXI_ADDR_W-1:0] araddr_aligned;
	axi_burst_e            arburst;
	logic [BTT_W-1:0]      rmn_sub1;     // remaining beats - 1
	logic [BND_W-1:0]      rmn_bnd_sub1; // beats left in this page - 1
	logic [AXI_STRB_W-1:0] first_keep;
	logic [AXI_STRB_W-1:0] last_keep;
	logic [7:0]            cmp_res;
	logic                  cmp_leq_pre;
	logic                  last_burst;
	logic                  incr;
	logic                  cmp_en;
	logic [BTT_W-1:0]      op_a;
	logic [BTT_W-1:0]      op_b;
	logic                  a_leq_b;
	logic [BTT_W-1:0]      burst_beats;
	logic                  dcmd_fire;
	logic                  ar_next;

	assign incr         = (arburst == AXI_BURST_INCR);
	assign dcmd_ready_o = (state == ST_IDLE);
	assign dcmd_fire    = dcmd_valid_i & dcmd_ready_o;
	assign ar_next      = arvalid_o & arready_i & ~last_burst;

	assign op_a = (state == ST_CMP0) ? rmn_sub1 : BTT_W'(cmp_res);
	assign op_b = (state == ST_CMP0) ? (incr ? INCR_CAP_SUB1 : FIXED_CAP_SUB1) :
		BTT_W'(rmn_bnd_sub1);

	// fixed bursts never move, so the boundary compare always keeps phase 0
	assign a_leq_b = (op_a <= op_b) | ((state == ST_CMP1) & ~incr);
	assign cmp_en  = ((state == ST_CMP0) & credit_ok_i) | ((state == ST_CMP1) & incr);

	assign burst_beats    = BTT_W'(cmp_res) + 1'b1;
	assign araddr_aligned = {araddr[AXI_ADDR_W-1:SIZE_LOG2], SIZE_LOG2'(0)};

	assign ar_o   = '{addr: araddr, len: cmp_res, burst: arburst};
	assign info_o = '{first_keep: first_keep, last_keep: last_keep, last_burst: last_burst};

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			state     <= ST_IDLE;
			arvalid_o <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (dcmd_valid_i)
						state <= ST_CMP0;
				ST_CMP0:
					if (credit_ok_i) // no credit, hold here
						state <= ST_CMP1;
				ST_CMP1:
				begin
					state     <= ST_LAUNCH;
					arvalid_o <= 1'b1;
				end
				ST_LAUNCH:
					if (arready_i)
					begin
						state     <= last_burst ? ST_IDLE : ST_CMP0;
						arvalid_o <= 1'b0;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (dcmd_fire)
		begin
			araddr       <= dcmd_i.base_addr;
			arburst      <= dcmd_i.fixed ? AXI_BURST_FIXED : AXI_BURST_INCR;
			rmn_sub1     <= dcmd_i.beats - 1'b1;
			rmn_bnd_sub1 <= ~dcmd_i.base_addr[BND_LOG2-1:SIZE_LOG2];
			first_keep   <= dcmd_i.first_keep;
			last_keep    <= dcmd_i.last_keep;
		end
		else if (ar_next)
		begin
			rmn_sub1 <= rmn_sub1 - burst_beats;
			if (incr)
			begin
				araddr       <= araddr_aligned + (AXI_ADDR_W'(burst_beats) << SIZE_LOG2);
				rmn_bnd_sub1 <= rmn_bnd_sub1 - burst_beats[BND_W-1:0]; // wraps to a full page
			end
		end

		if (cmp_en)
		begin
			cmp_res     <= a_leq_b ? op_a[7:0] : op_b[7:0];
			cmp_leq_pre <= a_leq_b;
		end

		if (state == ST_CMP1)
			last_burst <= cmp_leq_pre & a_leq_b; // both picked the remaining count
	end

endmodule

`default_nettype wire

// ==== mm2s_rdata_tagger.sv ====
`default_nettype none

module mm2s_rdata_tagger #(
	parameter int MAX_BUSY_BURSTS = 4
)(
	input  wire                            m_axi_aclk,
	input  wire                            m_axi_aresetn,
	input  wire axi_rd_pkg::axi_r_t        r_i,
	input  wire                            rvalid_i,
	output logic                           rready_o,
	input  wire dma_mm2s_pkg::burst_info_t info_i,
	input  wire                            info_valid_i,
	output logic                           info_pop_o,
	input  wire                            ar_fire_i,
	output logic                           credit_ok_o,
	output dma_mm2s_pkg::mm2s_beat_t       beat_o,
	output logic                           beat_valid_o,
	input  wire                            beat_ready_i
);
	import axi_rd_pkg::*;

	localparam int CNT_W = $clog2(MAX_BUSY_BURSTS + 1);

	logic                  first_beat; // next beat opens a command
	logic                  last_beat;
	logic                  beat_fire;
	logic [AXI_STRB_W-1:0] keep;
	logic [CNT_W-1:0]      busy_cnt;   // bursts issued and not yet drained

	// a beat needs its burst record before it can be tagged
	assign rready_o     = beat_ready_i & info_valid_i;
	assign beat_valid_o = rvalid_i & info_valid_i;
	assign beat_fire    = beat_valid_o & beat_ready_i;
	assign info_pop_o   = beat_fire & r_i.last;

	assign last_beat = r_i.last & info_i.last_burst;
	assign keep = ({AXI_STRB_W{~first_beat}} | info_i.first_keep) &
		({AXI_STRB_W{~last_beat}} | info_i.last_keep);

	assign beat_o = '{data: r_i.data, keep: keep, user: r_i.resp, last: last_beat};

	assign credit_ok_o = (busy_cnt < CNT_W'(MAX_BUSY_BURSTS));

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			first_beat <= 1'b1;
		else if (beat_fire)
			first_beat <= last_beat;
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			busy_cnt <= '0;
		else if (ar_fire_i != info_pop_o)
			busy_cnt <= ar_fire_i ? busy_cnt + 1'b1 : busy_cnt - 1'b1;
	end

endmodule

`default_nettype wire

// ==== axi_dma_mm2s.sv ====
`default_nettype none

module axi_dma_mm2s #(
	parameter int MAX_BURST_LEN = 8,
	parameter int CMD_DEPTH     = 4,
	parameter int RDATA_DEPTH   = 64
)(
	input  wire                          m_axi_aclk,
	input  wire                          m_axi_aresetn,
	input  wire dma_mm2s_pkg::mm2s_cmd_t s_cmd_i,
	input  wire                          s_cmd_valid_i,
	output logic                         s_cmd_ready_o,
	output dma_mm2s_pkg::mm2s_beat_t     m_mm2s_o,
	output logic                         m_mm2s_valid_o,
	input  wire                          m_mm2s_ready_i,
	output axi_rd_pkg::axi_ar_t          m_axi_ar_o,
	output logic [2:0]                   m_axi_arsize_o,
	output logic [3:0]                   m_axi_arcache_o,
	output logic [2:0]                   m_axi_arprot_o,
	output logic                         m_axi_arvalid_o,
	input  wire                          m_axi_arready_i,
	input  wire axi_rd_pkg::axi_r_t      m_axi_r_i,
	input  wire                          m_axi_rvalid_i,
	output logic                         m_axi_rready_o
);
	import axi_rd_pkg::*;
	import dma_mm2s_pkg::*;

	localparam int INFO_DEPTH = 4;
	// worst-case burst size reserved in the read-data FIFO per credit
	localparam int BURST_SLOT = (MAX_BURST_LEN > FIXED_MAX_LEN) ? MAX_BURST_LEN : FIXED_MAX_LEN;
	localparam int MAX_BUSY_BURSTS = RDATA_DEPTH / BURST_SLOT;

	mm2s_cmd_t   cmd_q;
	logic        cmd_q_valid;
	logic        cmd_q_ready;
	mm2s_dcmd_t  dcmd;
	logic        dcmd_valid;
	logic        dcmd_ready;
	burst_info_t info_in;
	logic        info_wr_ready;
	burst_info_t info_head;
	logic        info_valid;
	logic        info_pop;
	logic        ar_fire;
	logic        tag_credit_ok;
	logic        credit_ok;
	mm2s_beat_t  rd_beat;
	logic        rd_beat_valid;
	logic        rd_beat_ready;

	assign m_axi_arsize_o  = AXI_SIZE_LOG2;
	assign m_axi_arcache_o = AXI_CACHE_RD;
	assign m_axi_arprot_o  = AXI_PROT_RD;

	assign ar_fire   = m_axi_arvalid_o & m_axi_arready_i;
	assign credit_ok = tag_credit_ok & info_wr_ready; // info FIFO needs a slot too

	mm2s_sync_fifo #(.DEPTH(CMD_DEPTH), .T(mm2s_cmd_t)) cmd_fifo_inst (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.wr_i(s_cmd_i), .wr_valid_i(s_cmd_valid_i), .wr_ready_o(s_cmd_ready_o),
		.rd_o(cmd_q), .rd_valid_o(cmd_q_valid), .rd_ready_i(cmd_q_ready)
	);

	mm2s_cmd_decode decode_inst (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.cmd_i(cmd_q), .cmd_valid_i(cmd_q_valid), .cmd_ready_o(cmd_q_ready),
		.dcmd_o(dcmd), .dcmd_valid_o(dcmd_valid), .dcmd_ready_i(dcmd_ready)
	);

	mm2s_burst_splitter #(.MAX_BURST_LEN(MAX_BURST_LEN)) splitter_inst (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.dcmd_i(dcmd), .dcmd_valid_i(dcmd_valid), .dcmd_ready_o(dcmd_ready),
		.credit_ok_i(credit_ok), .ar_o(m_axi_ar_o), .arvalid_o(m_axi_arvalid_o),
		.arready_i(m_axi_arready_i), .info_o(info_in)
	);

	mm2s_sync_fifo #(.DEPTH(INFO_DEPTH), .T(burst_info_t)) info_fifo_inst (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.wr_i(info_in), .wr_valid_i(ar_fire), .wr_ready_o(info_wr_ready),
		.rd_o(info_head), .rd_valid_o(info_valid), .rd_ready_i(info_pop)
	);

	mm2s_rdata_tagger #(.MAX_BUSY_BURSTS(MAX_BUSY_BURSTS)) tagger_inst (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.r_i(m_axi_r_i), .rvalid_i(m_axi_rvalid_i), .rready_o(m_axi_rready_o),
		.info_i(info_head), .info_valid_i(info_valid), .info_pop_o(info_pop),
		.ar_fire_i(ar_fire), .credit_ok_o(tag_credit_ok),
		.beat_o(rd_beat), .beat_valid_o(rd_beat_valid), .beat_ready_i(rd_beat_ready)
	);

	mm2s_sync_fifo #(.DEPTH(RDATA_DEPTH), .T(mm2s_beat_t)) rdata_fifo_inst (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.wr_i(rd_beat), .wr_valid_i(rd_beat_valid), .wr_ready_o(rd_beat_ready),
		.rd_o(m_mm2s_o), .rd_valid_o(m_mm2s_valid_o), .rd_ready_i(m_mm2s_ready_i)
	);

endmodule

`default_nettype wire

// ==== tb_axi_dma_mm2s_asserts.sv ====
`default_nettype none

module tb_axi_dma_mm2s_asserts #(
	parameter int MAX_BURST_LEN = 8
)(
	input wire                      m_axi_aclk,
	input wire                      m_axi_aresetn,
	input wire axi_rd_pkg::axi_ar_t ar_i,
	input wire                      arvalid_i,
	input wire                      arready_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import axi_rd_pkg::*;
	import dma_mm2s_pkg::*;

	int unsigned fail_cnt = 0;

	// request held until the slave takes it
	ar_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
		else
		begin
			fail_cnt++;
			$error("AR request changed or dropped before arready");
		end

	ar_no_cross: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		arvalid_i && ar_i.burst == AXI_BURST_INCR |->
		{2'b00, ar_i.addr[11:2]} + ar_i.len <= 12'd1023) // last beat still in the page
		else
		begin
			fail_cnt++;
			$error("incrementing burst crosses a 4 KB boundary");
		end

	ar_len_cap: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		arvalid_i |-> ar_i.len < MAX_BURST_LEN)
		else
		begin
			fail_cnt++;
			$error("burst longer than the configured maximum");
		end

	ar_fixed_cap: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		arvalid_i && ar_i.burst == AXI_BURST_FIXED |-> ar_i.len < FIXED_MAX_LEN)
		else
		begin
			fail_cnt++;
			$error("fixed burst longer than 16 beats");
		end

endmodule

bind mm2s_burst_splitter tb_axi_dma_mm2s_asserts #(.MAX_BURST_LEN(MAX_BURST_LEN)) asserts_inst (
	.m_axi_aclk(m_axi_aclk),
	.m_axi_aresetn(m_axi_aresetn),
	.ar_i(ar_o),
	.arvalid_i(arvalid_o),
	.arready_i(arready_i)
);

`default_nettype wire

// ==== tb_axi_dma_mm2s.sv ====
`default_nettype none

module tb_axi_dma_mm2s;
	timeunit 1ns;
	timeprecision 1ps;
	import axi_rd_pkg::*;
	import dma_mm2s_pkg::*;

	localparam int TIMEOUT = 20000; // cycles allowed per wait

	logic        m_axi_aclk = 1'b0;
	logic        m_axi_aresetn;
	mm2s_cmd_t   s_cmd_i;
	logic        s_cmd_valid_i;
	logic        s_cmd_ready_o;
	mm2s_beat_t  m_mm2s_o;
	logic        m_mm2s_valid_o;
	logic        m_mm2s_ready_i;
	axi_ar_t     m_axi_ar_o;
	logic [2:0]  m_axi_arsize_o;
	logic [3:0]  m_axi_arcache_o;
	logic [2:0]  m_axi_arprot_o;
	logic        m_axi_arvalid_o;
	logic        m_axi_arready_i;
	axi_r_t      m_axi_r_i;
	logic        m_axi_rvalid_i;
	logic        m_axi_rready_o;

	integer      seed = 32'he5e26a2f;
	logic        out_rand = 1'b0; // random ready on the output stream
	mm2s_beat_t  exp_q[$];
	axi_ar_t     ar_q[$];   // accepted, not yet answered
	axi_ar_t     ar_log[$]; // every accepted burst of the current check

	axi_dma_mm2s #(.MAX_BURST_LEN(8), .CMD_DEPTH(4), .RDATA_DEPTH(64)) axi_dma_mm2s_inst (.*);

	initial
	begin
		forever
			#5 m_axi_aclk = ~m_axi_aclk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("error at %0t: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	task automatic tick;
		@(posedge m_axi_aclk);
		#1;
	endtask

	// memory contents of the slave model
	function automatic logic [31:0] word_at(input logic [31:0] a);
		return {a[15:0], ~a[15:0]};
	endfunction

	function automatic axi_resp_e resp_at(input logic [31:0] a);
		return (a >= 32'h8000 && a <= 32'h8fff) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
	endfunction

	function automatic void expect_beats(input mm2s_cmd_t cmd);
		int          ofs;
		int          nbytes;
		int          nbeats;
		logic [31:0] a;
		mm2s_beat_t  b;
		ofs    = cmd.base_addr[1:0];
		nbytes = ofs + cmd.btt;
		nbeats = (nbytes + 3) / 4;
		for (int i = 0; i < nbeats; i++)
		begin
			a      = {cmd.base_addr[31:2], 2'b00} + (cmd.fixed ? 0 : 4 * i);
			b.data = word_at(a);
			b.keep = 4'hf;
			if (i == 0)
				b.keep &= 4'hf << ofs; // bytes before the start are dropped
			if (i == nbeats - 1 && nbytes % 4 != 0)
				b.keep &= 4'hf >> (4 - nbytes % 4);
			b.user = resp_at(a);
			b.last = (i == nbeats - 1);
			exp_q.push_back(b);
		end
	endfunction

	// waits for a handshake on the command stream or on the R channel
	task automatic wait_fire(input bit r_chan, input string what);
		int   n;
		logic fire;
		for (n = 0; n < TIMEOUT; n++)
		begin
			@(negedge m_axi_aclk);
			fire = r_chan ? m_axi_rready_o : s_cmd_ready_o;
			tick();
			if (fire)
				break;
		end
		if (n == TIMEOUT)
			stop_on_error({"timeout: no handshake on the ", what});
	endtask

	task automatic send_cmd(input logic [23:0] btt, input logic [31:0] addr, input logic fixed);
		mm2s_cmd_t cmd;
		cmd = '{btt: btt, base_addr: addr, fixed: fixed};
		expect_beats(cmd);
		s_cmd_i       = cmd;
		s_cmd_valid_i = 1'b1;
		wait_fire(1'b0, "command stream");
		s_cmd_valid_i = 1'b0;
	endtask

	task automatic wait_drain;
		int n;
		for (n = 0; n < TIMEOUT; n++)
		begin
			@(posedge m_axi_aclk);
			if (exp_q.size() == 0)
				break;
		end
		if (n == TIMEOUT)
			stop_on_error("timeout: expected beats never reached the output stream");
		#1;
	endtask

	task automatic check_bursts(input logic [31:0] base, input int beats, input logic fixed);
		logic [31:0] next;
		int          total;
		next  = base;
		total = 0;
		foreach (ar_log[k])
		begin
			check_val($sformatf("burst %0d address", k), ar_log[k].addr, next);
			check_val($sformatf("burst %0d type", k), ar_log[k].burst,
				fixed ? AXI_BURST_FIXED : AXI_BURST_INCR);
			total += ar_log[k].len + 1;
			if (!fixed)
				next = {ar_log[k].addr[31:2], 2'b00} + 4 * (ar_log[k].len + 1);
		end
		check_val("beats over all bursts", total, beats);
	endtask

	// AR side of the slave, about 70% ready
	initial
	begin
		forever
		begin
			@(negedge m_axi_aclk);
			if (m_axi_arvalid_o && m_axi_arready_i)
			begin
				check_val("arsize", m_axi_arsize_o, 3'd2);
				check_val("arcache", m_axi_arcache_o, 4'b0011);
				check_val("arprot", m_axi_arprot_o, 3'b000);
				check_val("arlen within cap", m_axi_ar_o.len <= 8'd7, 1'b1);
				if (m_axi_ar_o.burst == AXI_BURST_INCR)
					check_val("burst inside 4 KB", m_axi_ar_o.addr[11:2] + m_axi_ar_o.len <= 1023,
						1'b1);
				ar_q.push_back(m_axi_ar_o);
				ar_log.push_back(m_axi_ar_o);
			end
			tick();
			m_axi_arready_i = ({$random(seed)} % 10) < 7;
		end
	end

	// R side, beats with random gaps
	initial
	begin
		axi_ar_t     ar;
		logic [31:0] a;
		forever
		begin
			tick();
			if (ar_q.size() != 0)
			begin
				ar = ar_q.pop_front();
				for (int b = 0; b <= ar.len; b++)
				begin
					repeat ({$random(seed)} % 3)
						tick();
					a = {ar.addr[31:2], 2'b00} + (ar.burst == AXI_BURST_FIXED ? 0 : 4 * b);
					m_axi_r_i      = '{data: word_at(a), resp: resp_at(a), last: (b == ar.len)};
					m_axi_rvalid_i = 1'b1;
					wait_fire(1'b1, "R channel");
					m_axi_rvalid_i = 1'b0;
				end
			end
		end
	end

	initial
	begin
		forever
		begin
			tick();
			m_mm2s_ready_i = out_rand ? ({$random(seed)} % 4 != 0) : 1'b1;
		end
	end

	// AR channel assertions bound into the splitter
	initial
	begin
		forever
		begin
			@(negedge m_axi_aclk);
			if (axi_dma_mm2s_inst.splitter_inst.asserts_inst.fail_cnt != 0)
				stop_on_error("an assertion on the AR channel failed");
		end
	end

	// compare process
	initial
	begin
		mm2s_beat_t got;
		mm2s_beat_t exp;
		int         cnt;
		cnt = 0;
		forever
		begin
			@(negedge m_axi_aclk);
			if (m_mm2s_valid_o && m_mm2s_ready_i)
			begin
				got = m_mm2s_o;
				if (exp_q.size() == 0)
					stop_on_error("an output beat arrived while none was expected");
				exp = exp_q.pop_front();
				check_val($sformatf("beat %0d data", cnt), got.data, exp.data);
				check_val($sformatf("beat %0d keep", cnt), got.keep, exp.keep);
				check_val($sformatf("beat %0d user", cnt), got.user, exp.user);
				check_val($sformatf("beat %0d last", cnt), got.last, exp.last);
				cnt++;
			end
		end
	end

	initial
	begin
		logic [23:0] rbtt;
		logic [31:0] raddr;
		logic        rfix;
		m_axi_aresetn   = 1'b0;
		s_cmd_i         = '0;
		s_cmd_valid_i   = 1'b0;
		m_mm2s_ready_i  = 1'b0;
		m_axi_arready_i = 1'b0;
		m_axi_r_i       = '0;
		m_axi_rvalid_i  = 1'b0;
		repeat (10)
			@(posedge m_axi_aclk);
		#1;
		m_axi_aresetn = 1'b1;

		send_cmd(24'd32, 32'h0000_1000, 1'b0); // eight full beats
		wait_drain();
		ar_log.delete();
		send_cmd(24'd600, 32'h0000_0ff0, 1'b0); // runs over the 4 KB line
		wait_drain();
		check_bursts(32'h0000_0ff0, 150, 1'b0);
		send_cmd(24'd9, 32'h0000_0103, 1'b0);
		send_cmd(24'd7, 32'h0000_0103, 1'b0); // last keep 0011
		wait_drain();
		ar_log.delete();
		send_cmd(24'd80, 32'h0000_2000, 1'b1); // 20 beats at one address
		wait_drain();
		check_bursts(32'h0000_2000, 20, 1'b1);
		send_cmd(24'd64, 32'h0000_8000, 1'b0); // slverr region
		wait_drain();

		out_rand = 1'b1;
		for (int k = 0; k < 20; k++)
		begin
			rbtt  = 24'd1 + ({$random(seed)} % 200);
			raddr = {$random(seed)} % 32'h0001_0000;
			rfix  = ({$random(seed)} % 4) == 0;
			send_cmd(rbtt, raddr, rfix);
		end
		wait_drain();
		check_val("unanswered AR requests", ar_q.size(), 0);

		if (axi_dma_mm2s_inst.splitter_inst.asserts_inst.fail_cnt == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
			stop_on_error("an assertion on the AR channel failed");
	end

endmodule

`default_nettype wire

// ==== axi_dma_mm2s.f ====
axi_rd_pkg.sv
dma_mm2s_pkg.sv
mm2s_sync_fifo.sv
mm2s_cmd_decode.sv
mm2s_burst_splitter.sv
mm2s_rdata_tagger.sv
axi_dma_mm2s.sv
tb_axi_dma_mm2s_asserts.sv
tb_axi_dma_mm2s.sv

// ==== Bender.yml ====
package:
  name: axi_dma_mm2s

sources:
  - files:
      - axi_rd_pkg.sv
      - dma_mm2s_pkg.sv
      - mm2s_sync_fifo.sv
      - mm2s_cmd_decode.sv
      - mm2s_burst_splitter.sv
      - mm2s_rdata_tagger.sv
      - axi_dma_mm2s.sv
  - target: test
    files:
      - tb_axi_dma_mm2s_asserts.sv
      - tb_axi_dma_mm2s.sv
